/* hw/cpu_pkg.sv */
package cpu_pkg;

    // default sizes, overridden from the top level
    localparam int unsigned XLEN      = 32;
    localparam int unsigned PHYS_REGS = 128;
    localparam int unsigned ROB_DEPTH = 64;
    localparam int unsigned WB_WIDTH  = 4;

    localparam int unsigned PRF_TAG_W = $clog2(PHYS_REGS);
    localparam int unsigned ROB_IDX_W = $clog2(ROB_DEPTH);

    typedef logic [PRF_TAG_W-1:0] prf_tag_t;
    typedef logic [ROB_IDX_W-1:0] rob_idx_t;

    // result from one function unit
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] value;
        prf_tag_t        dest_prf;
        rob_idx_t        rob_idx;
        logic            exception;
        logic            mispred;
        logic            is_jtype;
        logic [XLEN-1:0] jtype_value;
    } fu_wb_t;

    // load data coming back from the LSQ
    typedef struct packed {
        logic            valid;
        rob_idx_t        rob_idx;
        logic [XLEN-1:0] data;
        prf_tag_t        dest_prf;
    } load_wb_t;

    typedef struct packed {
        logic            valid;
        rob_idx_t        rob_idx;
        logic            exception;
        logic            mispred;
        logic [XLEN-1:0] value;
    } rob_wb_t;

    typedef struct packed {
        logic            valid;
        prf_tag_t        phys_tag;
        logic [XLEN-1:0] value;
    } cdb_entry_t;

    typedef struct packed {
        logic            valid;
        rob_idx_t        rob_idx;
        logic [XLEN-1:0] value;
        logic            exception;
        logic            mispred;
    } commit_t;

endpackage

/* hw/load_wb_queue.sv */
`timescale 1ns/100ps

module load_wb_queue #(
    parameter int unsigned LQ_WB_DEPTH = 4
)(
    input  logic              clock,
    input  logic              rst_n_i,
    input  cpu_pkg::load_wb_t push_i,
    input  logic              pop_i,
    output cpu_pkg::load_wb_t head_o,
    output logic              overflow_o
);

    import cpu_pkg::*;

    localparam int unsigned PTR_W = (LQ_WB_DEPTH > 1) ? $clog2(LQ_WB_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(LQ_WB_DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(LQ_WB_DEPTH);

    load_wb_t          mem [LQ_WB_DEPTH];
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W-1:0]  wr_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_push;
    logic              do_pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(LQ_WB_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign do_pop  = pop_i && (count != '0);
    // a pop in the same cycle frees the slot for a push into a full queue
    assign do_push = push_i.valid && ((count != FULL_CNT) || do_pop);

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_ptr     <= '0;
            wr_ptr     <= '0;
            count      <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // sticky, load was lost
            if (push_i.valid && !do_push) begin
                overflow_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr] <= push_i;
        end
    end

    always_comb begin
        head_o       = mem[rd_ptr];
        head_o.valid = (count != '0);
    end

    a_no_pop_empty: assert property (@(posedge clock) disable iff (!rst_n_i)
        pop_i |-> (count != '0))
        else $error("load_wb_queue: pop while empty");

endmodule

/* hw/complete_stage.sv */
`timescale 1ns/100ps

module complete_stage #(
    parameter int unsigned WB_WIDTH = cpu_pkg::WB_WIDTH
)(
    input  cpu_pkg::fu_wb_t     [WB_WIDTH-1:0]                    fu_wb_i,
    input  cpu_pkg::load_wb_t                                     load_i,
    output logic                                                  load_taken_o,
    output logic                [WB_WIDTH-1:0]                    prf_wr_en_o,
    output cpu_pkg::prf_tag_t   [WB_WIDTH-1:0]                    prf_waddr_o,
    output logic                [WB_WIDTH-1:0][cpu_pkg::XLEN-1:0] prf_wdata_o,
    output cpu_pkg::rob_wb_t    [WB_WIDTH-1:0]                    rob_wb_o,
    output cpu_pkg::cdb_entry_t [WB_WIDTH-1:0]                    cdb_o
);

    logic [WB_WIDTH-1:0] load_sel;

    // load goes to the lowest lane without an FU result
    always_comb begin
        load_sel = '0;
        for (int i = 0; i < WB_WIDTH; i++) begin
            if (load_i.valid && !fu_wb_i[i].valid && (load_sel == '0)) begin
                load_sel[i] = 1'b1;
            end
        end
    end

    assign load_taken_o = |load_sel;

    always_comb begin
        prf_wr_en_o = '0;
        prf_waddr_o = '0;
        prf_wdata_o = '0;
        rob_wb_o    = '0;
        cdb_o       = '0;

        for (int i = 0; i < WB_WIDTH; i++) begin
            if (fu_wb_i[i].valid) begin
                prf_wr_en_o[i] = 1'b1;
                prf_waddr_o[i] = fu_wb_i[i].dest_prf;
                prf_wdata_o[i] = fu_wb_i[i].value;

                rob_wb_o[i].valid     = 1'b1;
                rob_wb_o[i].rob_idx   = fu_wb_i[i].rob_idx;
                rob_wb_o[i].exception = fu_wb_i[i].exception;
                rob_wb_o[i].mispred   = fu_wb_i[i].mispred;
                // jumps report the target to the ROB, the link value to the PRF
                if (fu_wb_i[i].is_jtype) begin
                    rob_wb_o[i].value = fu_wb_i[i].jtype_value;
                end else begin
                    rob_wb_o[i].value = fu_wb_i[i].value;
                end

                cdb_o[i].valid    = 1'b1;
                cdb_o[i].phys_tag = fu_wb_i[i].dest_prf;
                cdb_o[i].value    = fu_wb_i[i].value;
            end else if (load_sel[i]) begin
                prf_wr_en_o[i] = 1'b1;
                prf_waddr_o[i] = load_i.dest_prf;
                prf_wdata_o[i] = load_i.data;

                rob_wb_o[i].valid   = 1'b1;
                rob_wb_o[i].rob_idx = load_i.rob_idx;
                rob_wb_o[i].value   = load_i.data;

                cdb_o[i].valid    = 1'b1;
                cdb_o[i].phys_tag = load_i.dest_prf;
                cdb_o[i].value    = load_i.data;
            end
        end
    end

endmodule

/* hw/phys_regfile.sv */
`timescale 1ns/100ps

module phys_regfile #(
    parameter int unsigned WB_WIDTH  = cpu_pkg::WB_WIDTH,
    parameter int unsigned PHYS_REGS = cpu_pkg::PHYS_REGS,
    parameter int unsigned XLEN      = cpu_pkg::XLEN
)(
    input  logic                                         clock,
    input  logic                                         rst_n_i,
    input  logic [WB_WIDTH-1:0]                          wr_en_i,
    input  logic [WB_WIDTH-1:0][$clog2(PHYS_REGS)-1:0]   waddr_i,
    input  logic [WB_WIDTH-1:0][XLEN-1:0]                wdata_i,
    input  logic [$clog2(PHYS_REGS)-1:0]                 raddr_i,
    output logic [XLEN-1:0]                              rdata_o
);

    logic [XLEN-1:0] regs [PHYS_REGS];

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int r = 0; r < PHYS_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int p = 0; p < WB_WIDTH; p++) begin
                // p0 is hardwired zero
                if (wr_en_i[p] && (waddr_i[p] != '0)) begin
                    regs[waddr_i[p]] <= wdata_i[p];
                end
            end
        end
    end

    // old value on a same-cycle write
    assign rdata_o = regs[raddr_i];

    for (genvar a = 0; a < WB_WIDTH; a++) begin : g_port_a
        for (genvar b = a + 1; b < WB_WIDTH; b++) begin : g_port_b
            a_no_dup_write: assert property (@(posedge clock) disable iff (!rst_n_i)
                !(wr_en_i[a] && wr_en_i[b] && (waddr_i[a] == waddr_i[b])
                  && (waddr_i[a] != '0)))
                else $error("phys_regfile: ports %0d and %0d write the same tag", a, b);
        end
    end

endmodule

/* hw/rob_tracker.sv */
`timescale 1ns/100ps

module rob_tracker #(
    parameter int unsigned ROB_DEPTH = cpu_pkg::ROB_DEPTH,
    parameter int unsigned WB_WIDTH  = cpu_pkg::WB_WIDTH
)(
    input  logic                                 clock,
    input  logic                                 rst_n_i,
    input  logic                                 alloc_i,
    output logic [$clog2(ROB_DEPTH)-1:0]         alloc_idx_o,
    output logic                                 rob_full_o,
    input  cpu_pkg::rob_wb_t [WB_WIDTH-1:0]      wb_i,
    output cpu_pkg::commit_t                     commit_o
);

    import cpu_pkg::*;

    localparam int unsigned IDX_W = $clog2(ROB_DEPTH);
    localparam int unsigned CNT_W = $clog2(ROB_DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(ROB_DEPTH);

    logic [IDX_W-1:0]     head;
    logic [IDX_W-1:0]     tail;
    logic [CNT_W-1:0]     count;
    logic [ROB_DEPTH-1:0] entry_valid;
    logic [ROB_DEPTH-1:0] entry_done;
    logic [ROB_DEPTH-1:0] entry_exc;
    logic [ROB_DEPTH-1:0] entry_mis;
    logic [XLEN-1:0]      entry_value [ROB_DEPTH];
    logic                 do_alloc;
    logic                 do_retire;

    function automatic logic [IDX_W-1:0] idx_next(input logic [IDX_W-1:0] idx);
        if (idx == IDX_W'(ROB_DEPTH - 1)) begin
            return '0;
        end
        return idx + 1'b1;
    endfunction

    assign rob_full_o  = (count == FULL_CNT);
    assign alloc_idx_o = tail;
    assign do_alloc    = alloc_i && !rob_full_o;
    assign do_retire   = entry_valid[head] && entry_done[head];

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            entry_valid <= '0;
            entry_done  <= '0;
            commit_o    <= '0;
        end else begin
            commit_o.valid <= 1'b0;
            if (do_retire) begin
                commit_o.valid     <= 1'b1;
                commit_o.rob_idx   <= head;
                commit_o.value     <= entry_value[head];
                commit_o.exception <= entry_exc[head];
                commit_o.mispred   <= entry_mis[head];
                entry_valid[head]  <= 1'b0;
                head               <= idx_next(head);
            end
            if (do_alloc) begin
                entry_valid[tail] <= 1'b1;
                entry_done[tail]  <= 1'b0;
                tail              <= idx_next(tail);
            end
            // completions may arrive in any order
            for (int i = 0; i < WB_WIDTH; i++) begin
                if (wb_i[i].valid) begin
                    entry_done[wb_i[i].rob_idx] <= 1'b1;
                end
            end
            case ({do_alloc, do_retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < WB_WIDTH; i++) begin
            if (wb_i[i].valid) begin
                entry_exc[wb_i[i].rob_idx]   <= wb_i[i].exception;
                entry_mis[wb_i[i].rob_idx]   <= wb_i[i].mispred;
                entry_value[wb_i[i].rob_idx] <= wb_i[i].value;
            end
        end
    end

    for (genvar g = 0; g < WB_WIDTH; g++) begin : g_wb_chk
        a_wb_allocated: assert property (@(posedge clock) disable iff (!rst_n_i)
            wb_i[g].valid |-> entry_valid[wb_i[g].rob_idx])
            else $error("rob_tracker: lane %0d completes an unallocated entry", g);
    end

    a_no_alloc_full: assert property (@(posedge clock) disable iff (!rst_n_i)
        alloc_i |-> !rob_full_o)
        else $error("rob_tracker: allocation while full");

endmodule

/* hw/complete_subsys.sv */
`timescale 1ns/100ps

module complete_subsys #(
    parameter int unsigned XLEN        = cpu_pkg::XLEN,
    parameter int unsigned PHYS_REGS   = cpu_pkg::PHYS_REGS,
    parameter int unsigned ROB_DEPTH   = cpu_pkg::ROB_DEPTH,
    parameter int unsigned WB_WIDTH    = cpu_pkg::WB_WIDTH,
    parameter int unsigned LQ_WB_DEPTH = 4
)(
    input  logic                                  clock,
    input  logic                                  rst_n_i,
    input  cpu_pkg::fu_wb_t     [WB_WIDTH-1:0]    fu_wb_i,
    input  cpu_pkg::load_wb_t                     load_wb_i,
    input  logic                                  alloc_i,
    output logic [$clog2(ROB_DEPTH)-1:0]          alloc_idx_o,
    output logic                                  rob_full_o,
    input  logic [$clog2(PHYS_REGS)-1:0]          prf_raddr_i,
    output logic [XLEN-1:0]                       prf_rdata_o,
    output cpu_pkg::cdb_entry_t [WB_WIDTH-1:0]    cdb_o,
    output cpu_pkg::commit_t                      commit_o,
    output logic                                  lq_overflow_o
);

    import cpu_pkg::*;

    load_wb_t                             lq_head;
    logic                                 load_taken;
    logic     [WB_WIDTH-1:0]              prf_wr_en;
    prf_tag_t [WB_WIDTH-1:0]              prf_waddr;
    logic     [WB_WIDTH-1:0][XLEN-1:0]    prf_wdata;
    rob_wb_t  [WB_WIDTH-1:0]              rob_wb;

    load_wb_queue #(
        .LQ_WB_DEPTH (LQ_WB_DEPTH)
    ) u_load_q (
        .clock      (clock),
        .rst_n_i    (rst_n_i),
        .push_i     (load_wb_i),
        .pop_i      (load_taken),
        .head_o     (lq_head),
        .overflow_o (lq_overflow_o)
    );

    complete_stage #(
        .WB_WIDTH (WB_WIDTH)
    ) u_stage (
        .fu_wb_i      (fu_wb_i),
        .load_i       (lq_head),
        .load_taken_o (load_taken),
        .prf_wr_en_o  (prf_wr_en),
        .prf_waddr_o  (prf_waddr),
        .prf_wdata_o  (prf_wdata),
        .rob_wb_o     (rob_wb),
        .cdb_o        (cdb_o)
    );

    phys_regfile #(
        .WB_WIDTH  (WB_WIDTH),
        .PHYS_REGS (PHYS_REGS),
        .XLEN      (XLEN)
    ) u_prf (
        .clock   (clock),
        .rst_n_i (rst_n_i),
        .wr_en_i (prf_wr_en),
        .waddr_i (prf_waddr),
        .wdata_i (prf_wdata),
        .raddr_i (prf_raddr_i),
        .rdata_o (prf_rdata_o)
    );

    rob_tracker #(
        .ROB_DEPTH (ROB_DEPTH),
        .WB_WIDTH  (WB_WIDTH)
    ) u_rob (
        .clock       (clock),
        .rst_n_i     (rst_n_i),
        .alloc_i     (alloc_i),
        .alloc_idx_o (alloc_idx_o),
        .rob_full_o  (rob_full_o),
        .wb_i        (rob_wb),
        .commit_o    (commit_o)
    );

endmodule

/* verification/complete_subsys_tb.sv */
`timescale 1ns/100ps

module complete_subsys_tb;

    import cpu_pkg::*;

    localparam int unsigned LQ_DEPTH   = 4;
    localparam int unsigned DRAIN_MAX  = 1000;

    logic                      clock;
    logic                      rst_n_i;
    fu_wb_t     [WB_WIDTH-1:0] fu_wb;
    load_wb_t                  load_wb;
    logic                      alloc;
    rob_idx_t                  alloc_idx;
    logic                      rob_full;
    prf_tag_t                  prf_raddr;
    logic       [XLEN-1:0]     prf_rdata;
    cdb_entry_t [WB_WIDTH-1:0] cdb;
    commit_t                   commit;
    logic                      lq_overflow;

    // reference model state
    logic [31:0]     rng_state;
    int unsigned     errors;
    int unsigned     checks;
    load_wb_t        lq_model [$];
    rob_idx_t        rob_order [$];
    rob_idx_t        pool [$];
    logic [XLEN-1:0] prf_model [PHYS_REGS];
    logic            done_m [ROB_DEPTH];
    commit_t         entry_m [ROB_DEPTH];
    commit_t         exp_commit;
    rob_idx_t        tail_m;
    logic            overflow_m;
    prf_tag_t        last_wr_tag;
    int              load_lane_m;
    int unsigned     guard;

    complete_subsys #(
        .LQ_WB_DEPTH (LQ_DEPTH)
    ) complete_subsys_i (
        .clock         (clock),
        .rst_n_i       (rst_n_i),
        .fu_wb_i       (fu_wb),
        .load_wb_i     (load_wb),
        .alloc_i       (alloc),
        .alloc_idx_o   (alloc_idx),
        .rob_full_o    (rob_full),
        .prf_raddr_i   (prf_raddr),
        .prf_rdata_o   (prf_rdata),
        .cdb_o         (cdb),
        .commit_o      (commit),
        .lq_overflow_o (lq_overflow)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // random allocated entry that has no result in flight yet
    function automatic rob_idx_t take_pending();
        int unsigned k;
        rob_idx_t    idx;
        k = next_rand() % pool.size();
        idx = pool[k];
        pool.delete(k);
        return idx;
    endfunction

    function automatic void mark_done(input rob_idx_t idx, input logic [XLEN-1:0] val,
                                      input logic exc, input logic mis);
        done_m[idx] = 1'b1;
        entry_m[idx] = '{1'b0, idx, val, exc, mis};
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("[ERROR] %0t %s", $time, msg);
    endtask

    task automatic check_outputs();
        cdb_entry_t exp;
        checks++;
        load_lane_m = -1;
        for (int i = 0; i < WB_WIDTH; i++) begin
            if ((lq_model.size() > 0) && !fu_wb[i].valid && (load_lane_m < 0)) begin
                load_lane_m = i;
            end
        end
        for (int i = 0; i < WB_WIDTH; i++) begin
            exp = '0;
            if (fu_wb[i].valid) begin
                exp = '{1'b1, fu_wb[i].dest_prf, fu_wb[i].value};
            end else if (i == load_lane_m) begin
                exp = '{1'b1, lq_model[0].dest_prf, lq_model[0].data};
            end
            a_cdb_lane: assert (cdb[i] === exp)
                else report_error($sformatf("cdb lane %0d is %h, expected %h", i, cdb[i], exp));
        end
        a_prf_read: assert (prf_rdata === prf_model[prf_raddr])
            else report_error($sformatf("prf tag %0d reads %h, expected %h",
                                        prf_raddr, prf_rdata, prf_model[prf_raddr]));
        a_commit: assert ((commit.valid === exp_commit.valid)
                          && (!exp_commit.valid || (commit === exp_commit)))
            else report_error($sformatf("commit is %h, expected %h", commit, exp_commit));
        a_rob_full: assert (rob_full === (rob_order.size() == ROB_DEPTH))
            else report_error($sformatf("rob_full_o is %b", rob_full));
        a_alloc_idx: assert (alloc_idx === tail_m)
            else report_error($sformatf("alloc_idx_o is %0d, expected %0d", alloc_idx, tail_m));
        a_overflow: assert (lq_overflow === overflow_m)
            else report_error($sformatf("lq_overflow_o is %b", lq_overflow));
    endtask

    // what the next rising edge does
    task automatic update_model();
        load_wb_t ld;
        exp_commit = '0;
        if ((rob_order.size() > 0) && done_m[rob_order[0]]) begin
            exp_commit = entry_m[rob_order[0]];
            exp_commit.valid = 1'b1;
            done_m[rob_order[0]] = 1'b0;
            void'(rob_order.pop_front());
        end
        for (int i = 0; i < WB_WIDTH; i++) begin
            if (fu_wb[i].valid) begin
                mark_done(fu_wb[i].rob_idx,
                          fu_wb[i].is_jtype ? fu_wb[i].jtype_value : fu_wb[i].value,
                          fu_wb[i].exception, fu_wb[i].mispred);
                if (fu_wb[i].dest_prf != '0) begin
                    prf_model[fu_wb[i].dest_prf] = fu_wb[i].value;
                end
                last_wr_tag = fu_wb[i].dest_prf;
            end
        end
        if (load_lane_m >= 0) begin
            ld = lq_model.pop_front();
            mark_done(ld.rob_idx, ld.data, 1'b0, 1'b0);
            prf_model[ld.dest_prf] = ld.data;
            last_wr_tag = ld.dest_prf;
        end
        if (load_wb.valid) begin
            if (lq_model.size() < LQ_DEPTH) begin
                lq_model.push_back(load_wb);
            end else begin
                // a lost load leaves its entry to a later result
                overflow_m = 1'b1;
                pool.push_back(load_wb.rob_idx);
            end
        end
        if (alloc) begin
            rob_order.push_back(tail_m);
            done_m[tail_m] = 1'b0;
            pool.push_back(tail_m);
            tail_m = (tail_m == rob_idx_t'(ROB_DEPTH - 1)) ? '0 : tail_m + 1'b1;
        end
    endtask

    // lane and load levels are chances out of 4
    task automatic drive_cycle(input int fu_level, input int ld_level, input bit want_alloc);
        fu_wb_t      lane;
        logic [31:0] r;
        @(negedge clock);
        fu_wb = '0;
        load_wb = '0;
        for (int i = 0; i < WB_WIDTH; i++) begin
            r = next_rand();
            if ((int'(r % 4) < fu_level) && (pool.size() > 0)) begin
                lane.valid       = 1'b1;
                lane.value       = next_rand();
                lane.dest_prf    = prf_tag_t'(32 * i + (r >> 4) % 25);
                lane.rob_idx     = take_pending();
                lane.exception   = r[9] & r[10];
                lane.mispred     = r[11] & r[12];
                lane.is_jtype    = r[13];
                lane.jtype_value = next_rand();
                fu_wb[i] = lane;
            end
        end
        r = next_rand();
        if ((int'(r % 4) < ld_level) && (pool.size() > 0)) begin
            // load tags sit apart from every FU lane's tags
            load_wb = '{1'b1, take_pending(), next_rand(),
                        prf_tag_t'(32 * ((r >> 4) % 4) + 25 + (r >> 8) % 7)};
        end
        alloc = want_alloc && (rob_order.size() < ROB_DEPTH);
        r = next_rand();
        prf_raddr = r[0] ? last_wr_tag : prf_tag_t'(r >> 8);
        #2;
        check_outputs();
        update_model();
    endtask

    initial begin
        rng_state = 32'd15655;
        errors = 0;
        checks = 0;
        rst_n_i = 1'b0;
        fu_wb = '0;
        load_wb = '0;
        alloc = 1'b0;
        prf_raddr = '0;
        for (int r = 0; r < PHYS_REGS; r++) begin
            prf_model[r] = '0;
        end
        for (int e = 0; e < ROB_DEPTH; e++) begin
            done_m[e] = 1'b0;
        end
        exp_commit = '0;
        tail_m = '0;
        overflow_m = 1'b0;
        last_wr_tag = '0;
        repeat (16) @(posedge clock);
        @(negedge clock);
        rst_n_i = 1'b1;

        // fill the ROB without completing anything
        repeat (ROB_DEPTH) drive_cycle(0, 0, 1'b1);
        // every lane busy so loads pile up until the queue overflows
        repeat (6) drive_cycle(4, 4, 1'b0);
        repeat (300) drive_cycle(2, 1, 1'b1);

        guard = 0;
        while (((pool.size() > 0) || (lq_model.size() > 0) || (rob_order.size() > 0))
               && (guard < DRAIN_MAX)) begin
            drive_cycle(2, 1, 1'b0);
            guard++;
        end
        // last retire shows up one cycle later
        drive_cycle(0, 0, 1'b0);
        if (guard == DRAIN_MAX) begin
            errors++;
            $display("timeout: the ROB and the load queue did not drain");
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* complete_subsys.f */
hw/cpu_pkg.sv
hw/load_wb_queue.sv
hw/complete_stage.sv
hw/phys_regfile.sv
hw/rob_tracker.sv
hw/complete_subsys.sv
verification/complete_subsys_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the completion subsystem testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    -f complete_subsys.f \
    --top-module complete_subsys_tb \
    -Mdir "$build_dir"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$("$build_dir"/Vcomplete_subsys_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1
